/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_synth_top
FILELIST  := compile.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard hdl/*.sv tests/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG) || ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "simulation did not pass, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
hdl/audio_pkg.sv
hdl/regbus_pkg.sv
hdl/uart_rx.sv
hdl/reg_write_framer.sv
hdl/tone_voice.sv
hdl/sigma_delta_dac.sv
hdl/synth_top.sv
tests/synth_top_properties.sv
tests/tb_synth_top.sv

/* hdl/audio_pkg.sv */
package audio_pkg;

	// unsigned sample shared by the voice and the DAC
	typedef logic [11:0] sample_t;

	typedef logic [3:0] volume_t;   // 0 is silent, 15 is full scale

	// waveform select, carried in bits 1..0 of the control register
	typedef enum logic [1:0] {
		WAVE_OFF      = 2'd0,
		WAVE_SAW      = 2'd1,
		WAVE_PULSE    = 2'd2,
		WAVE_TRIANGLE = 2'd3
	} wave_sel_t;

endpackage

/* hdl/reg_write_framer.sv */
`timescale 1ns/1ps

module reg_write_framer (
	input  logic                   CLK_IN,
	input  logic                   rst_n,
	input  logic                   byte_valid,
	input  regbus_pkg::byte_t      rx_byte,
	input  logic                   wr_ack,
	output logic                   wr_req,
	output regbus_pkg::reg_write_t wr,
	output regbus_pkg::byte_t      leds
);

	typedef enum logic {WAIT_ADDR, WAIT_DATA} frame_state_t;

	frame_state_t          state;
	regbus_pkg::reg_addr_t addr_q;      // address byte waiting for its data
	logic                  pair_done;
	logic                  can_issue;

	assign pair_done = byte_valid && (state == WAIT_DATA);
	assign can_issue = !wr_req && !wr_ack;   // previous handshake fully closed

	always_ff @(posedge CLK_IN or negedge rst_n) begin
		if (!rst_n) begin
			state  <= WAIT_ADDR;
			wr_req <= 1'b0;
			leds   <= '0;
		end else begin
			if (byte_valid)
				state <= (state == WAIT_ADDR) ? WAIT_DATA : WAIT_ADDR;

			if (pair_done) begin
				leds <= rx_byte;
				if (can_issue)
					wr_req <= 1'b1;
				// a pair arriving with a handshake still open is dropped
			end else if (wr_req && wr_ack) begin
				wr_req <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK_IN) begin
		if (byte_valid && state == WAIT_ADDR)
			addr_q <= rx_byte[4:0];   // upper three bits are ignored
		if (pair_done && can_issue) begin
			wr.addr <= addr_q;
			wr.data <= rx_byte;
		end
	end

endmodule

/* hdl/regbus_pkg.sv */
package regbus_pkg;

	typedef logic [7:0] byte_t;     // one serial data byte
	typedef logic [4:0] reg_addr_t;

	// one register write, as handed from the framer to the voice
	typedef struct packed {
		reg_addr_t addr;
		byte_t     data;
	} reg_write_t;

	// register map of the voice
	localparam reg_addr_t REG_FREQ_LO = 5'd0;   // frequency word bits 7..0
	localparam reg_addr_t REG_FREQ_HI = 5'd1;   // frequency word bits 15..8
	localparam reg_addr_t REG_CONTROL = 5'd2;   // bits 1..0 select the waveform
	localparam reg_addr_t REG_VOLUME  = 5'd3;   // bits 3..0

	// addresses 4 to 31 are accepted but change nothing

endpackage

/* hdl/sigma_delta_dac.sv */
`timescale 1ns/1ps

module sigma_delta_dac (
	input  logic               CLK_IN,
	input  logic               rst_n,
	input  audio_pkg::sample_t sample,
	output logic               audio
);

	audio_pkg::sample_t acc;       // residual error carried between cycles
	logic [12:0]        acc_sum;

	// carry out of the sum is the one-bit output
	assign acc_sum = {1'b0, acc} + {1'b0, sample};

	always_ff @(posedge CLK_IN or negedge rst_n) begin
		if (!rst_n) begin
			acc   <= '0;
			audio <= 1'b0;
		end else begin
			acc   <= acc_sum[11:0];
			audio <= acc_sum[12];   // density of ones tracks sample / 4096
		end
	end

endmodule

/* hdl/synth_top.sv */
`timescale 1ns/1ps

module synth_top #(
	parameter int CLK_FREQ  = 12_000_000,
	parameter int BAUDRATE  = 3_000_000,
	parameter int TONE_FREQ = 1_000_000
) (
	input  logic              CLK_IN,
	input  logic              rst_n,
	input  logic              rx,
	output logic              audio,
	output regbus_pkg::byte_t leds
);

	logic                   byte_valid;
	regbus_pkg::byte_t      rx_byte;
	logic                   wr_req;
	logic                   wr_ack;
	regbus_pkg::reg_write_t wr;
	audio_pkg::sample_t     sample;

	uart_rx #(
		.CLK_FREQ (CLK_FREQ),
		.BAUDRATE (BAUDRATE)
	) u_uart_rx (
		.CLK_IN     (CLK_IN),
		.rst_n      (rst_n),
		.rx         (rx),
		.rx_byte    (rx_byte),
		.byte_valid (byte_valid)
	);

	// address/data pairing, also owns the led byte
	reg_write_framer u_framer (
		.CLK_IN     (CLK_IN),
		.rst_n      (rst_n),
		.byte_valid (byte_valid),
		.rx_byte    (rx_byte),
		.wr_ack     (wr_ack),
		.wr_req     (wr_req),
		.wr         (wr),
		.leds       (leds)
	);

	tone_voice #(
		.CLK_FREQ  (CLK_FREQ),
		.TONE_FREQ (TONE_FREQ)
	) u_voice (
		.CLK_IN (CLK_IN),
		.rst_n  (rst_n),
		.wr_req (wr_req),
		.wr     (wr),
		.wr_ack (wr_ack),
		.sample (sample)
	);

	sigma_delta_dac u_dac (
		.CLK_IN (CLK_IN),
		.rst_n  (rst_n),
		.sample (sample),
		.audio  (audio)
	);

endmodule

/* hdl/tone_voice.sv */
`timescale 1ns/1ps

module tone_voice #(
	parameter int CLK_FREQ  = 12_000_000,
	parameter int TONE_FREQ = 1_000_000
) (
	input  logic                   CLK_IN,
	input  logic                   rst_n,
	input  logic                   wr_req,
	input  regbus_pkg::reg_write_t wr,
	output logic                   wr_ack,
	output audio_pkg::sample_t     sample
);

	localparam int DIV   = CLK_FREQ / TONE_FREQ;
	localparam int DIV_W = $clog2(DIV + 1);

	typedef logic [15:0] phase_t;

	phase_t                freq;          // phase step per tone clock
	phase_t                phase;
	audio_pkg::wave_sel_t  wave;
	audio_pkg::volume_t    vol;
	logic                  armed;         // set by the first accepted write
	logic [DIV_W-1:0]      div_cnt;
	logic                  tone_ce;
	logic [7:0]            wave_val;
	logic                  accept;

	assign accept  = wr_req && !wr_ack;
	assign tone_ce = (div_cnt == DIV_W'(DIV - 1));

	// register file and the slave side of the handshake
	always_ff @(posedge CLK_IN or negedge rst_n) begin
		if (!rst_n) begin
			wr_ack <= 1'b0;
			freq   <= '0;
			wave   <= audio_pkg::WAVE_OFF;
			vol    <= '0;
			armed  <= 1'b0;
		end else if (accept) begin
			wr_ack <= 1'b1;
			armed  <= 1'b1;
			case (wr.addr)
				regbus_pkg::REG_FREQ_LO: freq[7:0]  <= wr.data;
				regbus_pkg::REG_FREQ_HI: freq[15:8] <= wr.data;
				regbus_pkg::REG_CONTROL: wave <= audio_pkg::wave_sel_t'(wr.data[1:0]);
				regbus_pkg::REG_VOLUME:  vol  <= wr.data[3:0];
				default: ;   // unused address, write is still acknowledged
			endcase
		end else if (!wr_req && wr_ack) begin
			wr_ack <= 1'b0;
		end
	end

	// tone clock enable and phase accumulator
	always_ff @(posedge CLK_IN or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			phase   <= '0;
		end else if (tone_ce) begin
			div_cnt <= '0;
			phase   <= phase + freq;   // wraps, giving the tone period
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	always_comb begin
		case (wave)
			audio_pkg::WAVE_SAW:      wave_val = phase[15:8];
			audio_pkg::WAVE_PULSE:    wave_val = phase[15] ? 8'h00 : 8'hff;
			// fold the second half back down
			audio_pkg::WAVE_TRIANGLE: wave_val = phase[15] ? ~phase[14:7] : phase[14:7];
			default:                  wave_val = 8'h00;
		endcase
	end

	// 8 bit wave times 4 bit volume stays within 12 bits
	always_ff @(posedge CLK_IN or negedge rst_n) begin
		if (!rst_n)
			sample <= '0;
		else if (armed)
			sample <= audio_pkg::sample_t'(wave_val) * audio_pkg::sample_t'(vol);
		else
			sample <= '0;
	end

endmodule

/* hdl/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
	parameter int CLK_FREQ = 12_000_000,
	parameter int BAUDRATE = 3_000_000
) (
	input  logic              CLK_IN,
	input  logic              rst_n,
	input  logic              rx,
	output regbus_pkg::byte_t rx_byte,
	output logic              byte_valid
);

	localparam int BIT_CLKS  = CLK_FREQ / BAUDRATE;
	localparam int HALF_CLKS = BIT_CLKS / 2;
	localparam int CNT_W     = $clog2(BIT_CLKS + 1);

	typedef enum logic [1:0] {IDLE, START, DATA, STOP} rx_state_t;

	rx_state_t         state;
	logic [1:0]        rx_sync;     // two-flop synchronizer, line idles high
	logic [CNT_W-1:0]  bit_cnt;     // clocks into the current bit
	logic [2:0]        bit_idx;
	regbus_pkg::byte_t shreg;
	logic              rx_s;
	logic              bit_end;

	assign rx_s    = rx_sync[1];
	assign bit_end = (bit_cnt == CNT_W'(BIT_CLKS - 1));

	always_ff @(posedge CLK_IN or negedge rst_n) begin
		if (!rst_n) begin
			rx_sync    <= 2'b11;
			state      <= IDLE;
			bit_cnt    <= '0;
			bit_idx    <= '0;
			byte_valid <= 1'b0;
		end else begin
			rx_sync    <= {rx_sync[0], rx};
			byte_valid <= 1'b0;
			case (state)
				IDLE: begin
					bit_cnt <= '0;
					if (!rx_s)
						state <= START;
				end
				START: begin
					// check the start bit again half a bit later
					if (bit_cnt == CNT_W'(HALF_CLKS - 1)) begin
						bit_cnt <= '0;
						bit_idx <= '0;
						state   <= rx_s ? IDLE : DATA;   // high again means a glitch
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				DATA: begin
					if (bit_end) begin
						bit_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= STOP;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				STOP: begin
					if (bit_end) begin
						state      <= IDLE;
						byte_valid <= rx_s;   // low stop bit is a framing error
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// data path, lsb arrives first
	always_ff @(posedge CLK_IN) begin
		if (state == DATA && bit_end)
			shreg <= {rx_s, shreg[7:1]};
		if (state == STOP && bit_end && rx_s)
			rx_byte <= shreg;
	end

endmodule

/* tests/synth_top_properties.sv */
`timescale 1ns/1ps

module synth_top_properties (
	input logic                   CLK_IN,
	input logic                   rst_n,
	input logic                   byte_valid,
	input logic                   pair_done,
	input logic                   can_issue,
	input logic                   wr_req,
	input logic                   wr_ack,
	input regbus_pkg::reg_write_t wr
);

	req_until_ack: assert property (@(posedge CLK_IN) disable iff (!rst_n)
		wr_req && !wr_ack |=> wr_req)
		else $error("wr_req fell before wr_ack rose");

	// payload frozen for the whole request
	wr_stable: assert property (@(posedge CLK_IN) disable iff (!rst_n)
		wr_req |=> $stable(wr))
		else $error("wr changed while wr_req was high");

	ack_until_req_low: assert property (@(posedge CLK_IN) disable iff (!rst_n)
		wr_ack && wr_req |=> wr_ack)
		else $error("wr_ack fell while wr_req was still high");

	strobe_one_cycle: assert property (@(posedge CLK_IN) disable iff (!rst_n)
		byte_valid |=> !byte_valid)
		else $error("byte_valid stayed high for more than one cycle");

	// a pair completing during an open handshake is lost
	no_dropped_pair: assert property (@(posedge CLK_IN) disable iff (!rst_n)
		pair_done |-> can_issue)
		else $error("register pair arrived while a handshake was open");

endmodule

bind reg_write_framer synth_top_properties u_framer_props (
	.CLK_IN     (CLK_IN),
	.rst_n      (rst_n),
	.byte_valid (byte_valid),
	.pair_done  (pair_done),
	.can_issue  (can_issue),
	.wr_req     (wr_req),
	.wr_ack     (wr_ack),
	.wr         (wr)
);

// the voice sees only the handshake, so the framer-side inputs are tied off
bind tone_voice synth_top_properties u_voice_props (
	.CLK_IN     (CLK_IN),
	.rst_n      (rst_n),
	.byte_valid (1'b0),
	.pair_done  (1'b0),
	.can_issue  (1'b1),
	.wr_req     (wr_req),
	.wr_ack     (wr_ack),
	.wr         (wr)
);

/* tests/tb_synth_top.sv */
`timescale 1ns/1ps

module tb_synth_top;

	localparam int BIT_CLKS    = 4;        // 12 MHz clock at 3 Mbaud
	localparam int IDLE_CLKS   = 8;
	localparam int ACK_WAIT    = 40;
	localparam int CYCLE_LIMIT = 60_000;   // the tests take about 28k cycles

	logic              CLK_IN = 1'b0;
	logic              rst_n;
	logic              rx;
	logic              audio;
	regbus_pkg::byte_t leds;
	regbus_pkg::byte_t leds_model;   // data byte of the last complete pair

	int cycles = 0;
	int errors = 0;
	int cases_failed = 0;
	int base = 0;                    // error count when the current case began

	synth_top UUT (.*);

	always #4 CLK_IN = ~CLK_IN;

	always @(posedge CLK_IN)
		cycles <= cycles + 1;

	initial begin
		wait (cycles >= CYCLE_LIMIT);
		$display("Timeout after %0d cycles, the tests did not finish", CYCLE_LIMIT);
		$display("SOME TESTS FAILED");
		$finish;
	end

	task automatic expect_value(input string name, input int expected, input int got,
			input int tol);
		if (got - expected > tol || expected - got > tol) begin
			$display("Mismatch %s expected 0x%0h got 0x%0h", name, expected, got);
			errors++;
		end
	endtask

	// 8N1 frame after an idle gap with the lsb first
	task automatic send_byte(input regbus_pkg::byte_t value, input bit bad_stop);
		logic [9:0] frame;
		int         i;
		frame = {~bad_stop, value, 1'b0};
		repeat (IDLE_CLKS) @(posedge CLK_IN);
		for (i = 0; i < 10; i++) begin
			rx <= frame[i];
			repeat (BIT_CLKS) @(posedge CLK_IN);
		end
		rx <= 1'b1;   // back to idle even after a low stop bit
	endtask

	// data byte of a pair and the wr_ack pulse that must follow it
	task automatic send_data(input regbus_pkg::byte_t data);
		int n;
		bit seen;
		seen = 1'b0;
		send_byte(data, 1'b0);
		for (n = 0; n < ACK_WAIT && !(seen && !UUT.wr_ack); n++) begin
			@(negedge CLK_IN);
			seen |= UUT.wr_ack;
		end
		if (!(seen && !UUT.wr_ack)) begin
			$display("Register write got no complete wr_ack within %0d cycles", ACK_WAIT);
			errors++;
		end
		leds_model = data;
		expect_value("leds", int'(leds_model), int'(leds), 0);
	endtask

	task automatic write_reg(input regbus_pkg::reg_addr_t addr, input regbus_pkg::byte_t data);
		send_byte({3'($urandom), addr}, 1'b0);   // top three bits are don't care
		send_data(data);
	endtask

	// ones on the audio pin over 4096 cycles once the sample has settled
	task automatic count_ones(output int ones);
		ones = 0;
		repeat (200) @(negedge CLK_IN);
		repeat (4096) begin
			@(negedge CLK_IN);
			ones += int'(audio);
		end
	endtask

	task automatic report_case(input string name);
		if (errors == base) begin
			$display("%s: pass", name);
		end else begin
			cases_failed++;
			$display("%s: fail with %0d errors", name, errors - base);
		end
		base = errors;
	endtask

	task automatic reset_idle_state();
		int ones;
		@(negedge CLK_IN);
		expect_value("leds", 0, int'(leds), 0);
		count_ones(ones);
		expect_value("audio ones", 0, ones, 0);   // voice not armed yet
		report_case("reset idle state");
	endtask

	task automatic unused_address_writes();
		repeat (4)
			write_reg(5'($urandom_range(31, 4)), 8'($urandom));
		send_byte(8'($urandom_range(31, 4)), 1'b0);   // address byte on its own
		repeat (20) @(negedge CLK_IN);
		expect_value("leds", int'(leds_model), int'(leds), 0);
		send_data(8'($urandom));                       // completes that pair
		report_case("unused address writes");
	endtask

	task automatic framing_error_recovery();
		send_byte(8'($urandom), 1'b1);
		repeat (20) @(negedge CLK_IN);
		expect_value("leds", int'(leds_model), int'(leds), 0);
		write_reg(5'($urandom_range(31, 4)), 8'($urandom));   // framer still in step
		report_case("framing error recovery");
	endtask

	task automatic full_volume_pulse();
		int ones;
		write_reg(regbus_pkg::REG_FREQ_LO, 8'h00);
		write_reg(regbus_pkg::REG_FREQ_HI, 8'h00);   // phase holds at 0
		write_reg(regbus_pkg::REG_CONTROL, 8'(audio_pkg::WAVE_PULSE));
		write_reg(regbus_pkg::REG_VOLUME, 8'd15);
		count_ones(ones);
		expect_value("audio ones", 255 * 15, ones, 1);
		report_case("full volume pulse");
	endtask

	task automatic volume_scaling();
		int vol;
		int ones;
		vol = int'($urandom_range(15, 1));
		write_reg(regbus_pkg::REG_VOLUME, 8'(vol));
		count_ones(ones);
		expect_value("audio ones", 255 * vol, ones, 1);
		write_reg(regbus_pkg::REG_VOLUME, 8'h00);
		count_ones(ones);
		expect_value("audio ones at volume 0", 0, ones, 0);
		report_case("volume scaling");
	endtask

	task automatic wave_off_silence();
		int ones;
		write_reg(regbus_pkg::REG_CONTROL, 8'(audio_pkg::WAVE_OFF));
		write_reg(regbus_pkg::REG_VOLUME, 8'd15);
		count_ones(ones);
		expect_value("audio ones", 0, ones, 0);
		write_reg(5'($urandom_range(31, 4)), 8'($urandom));
		count_ones(ones);
		expect_value("audio ones after unused write", 0, ones, 0);
		report_case("wave off silence");
	endtask

	initial begin
		rst_n <= 1'b0;
		rx    <= 1'b1;
		leds_model = '0;
		void'($urandom(32'hb897_034f));
		repeat (5) @(posedge CLK_IN);
		rst_n <= 1'b1;
		reset_idle_state();
		unused_address_writes();
		framing_error_recovery();
		full_volume_pulse();
		volume_scaling();
		wave_off_silence();
		$display("6 cases run, %0d failed, %0d errors", cases_failed, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
